//--- verilog/tmr_cfg.svh
// TMR subsystem configuration
// Widths and reset behaviour shared by the package, the RTL and the bench

`ifndef TMR_CFG_SVH
`define TMR_CFG_SVH

// Width of one core data word
`define TMR_DATA_W 32

// Register port address width
`define TMR_ADDR_W 4

// Width of each per-core mismatch counter
`define TMR_CNT_W 8

// Set to 1'b1 to leave the group in lockstep run after reset
`define TMR_DEFAULT_IN_TMR 1'b0

`endif

//--- verilog/tmr_pkg.sv
// TMR subsystem types
// Redundancy modes, register map and the structs passed between blocks

`include "tmr_cfg.svh"

package tmr_pkg;

  // Redundancy mode of the core group
  typedef enum logic [2:0] {
    MODE_INDEP,
    MODE_RUN,
    MODE_UNLOAD,
    MODE_RELOAD,
    MODE_RAPID
  } tmr_mode_e;

  // Configuration word, setback sits in bit 0
  typedef struct packed {
    logic force_resynch;
    logic rapid_recovery;
    logic delay_resynch;
    logic reload_setback;
    logic setback;
  } tmr_cfg_t;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`TMR_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Control fields of a core bus request
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [3:0]  be;
    logic [29:0] addr;
  } core_bus_t;

  typedef struct packed {
    logic       single_mismatch;
    logic [2:0] error;
    logic       failure;
  } vote_stat_t;

  // Register map
  localparam logic [`TMR_ADDR_W-1:0] REG_ENABLE = 'd0;
  localparam logic [`TMR_ADDR_W-1:0] REG_CONFIG = 'd1;
  localparam logic [`TMR_ADDR_W-1:0] REG_MODE   = 'd2;
  localparam logic [`TMR_ADDR_W-1:0] REG_CNT0   = 'd3;
  localparam logic [`TMR_ADDR_W-1:0] REG_CNT1   = 'd4;
  localparam logic [`TMR_ADDR_W-1:0] REG_CNT2   = 'd5;

endpackage

//--- verilog/tmr_voter.sv
// Two-of-three majority voter
// Passes the majority payload and flags the deviating core

`timescale 1ns/10ps

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t             core0_i,
  input  payload_t             core1_i,
  input  payload_t             core2_i,
  output payload_t             voted_o,
  output tmr_pkg::vote_stat_t  stat_o
);

  logic eq01;
  logic eq02;
  logic eq12;

  // Pairwise agreement
  assign eq01 = (core0_i == core1_i);
  assign eq02 = (core0_i == core2_i);
  assign eq12 = (core1_i == core2_i);

  // Core1 and core2 only win when they agree against core0
  assign voted_o = (!eq01 && !eq02 && eq12) ? core1_i : core0_i;

  always_comb begin
    stat_o = '0;
    if (eq01 && eq02) begin
      // All three agree
      stat_o = '0;
    end else if (eq01) begin
      stat_o.single_mismatch = 1'b1;
      stat_o.error           = 3'b100;
    end else if (eq02) begin
      stat_o.single_mismatch = 1'b1;
      stat_o.error           = 3'b010;
    end else if (eq12) begin
      stat_o.single_mismatch = 1'b1;
      stat_o.error           = 3'b001;
    end else begin
      // No majority, every core is suspect
      stat_o.failure = 1'b1;
      stat_o.error   = 3'b111;
    end
  end

  // A failed vote is never reported as a correctable one
  a_fail_excl: assert final (!(stat_o.failure && stat_o.single_mismatch))
    else $error("voter reports failure and single mismatch together");

endmodule

//--- verilog/tmr_mismatch_cnt.sv
// Per-core mismatch counters
// Saturating counts of deviations, cleared individually by software

`timescale 1ns/10ps

`include "tmr_cfg.svh"

module tmr_mismatch_cnt (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [2:0]            incr_i,
  input  logic [2:0]            clr_i,
  output logic [`TMR_CNT_W-1:0] cnt_o [3]
);

  logic [`TMR_CNT_W-1:0] cnt_q [3];

  for (genvar i = 0; i < 3; i++) begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (clr_i[i]) begin
        // Clear wins over a simultaneous increment
        cnt_q[i] <= '0;
      end else if (incr_i[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end

    assign cnt_o[i] = cnt_q[i];

    // Saturated count stays nonzero until software clears it
    a_no_wrap: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (cnt_q[i] == '1) && !clr_i[i] |=> (cnt_q[i] != '0)
    ) else $error("mismatch counter %0d wrapped", i);
  end

endmodule

//--- verilog/tmr_ctrl_regs.sv
// TMR control register block
// Four-phase req/ack access to enable, configuration, mode and counters

`timescale 1ns/10ps

`include "tmr_cfg.svh"

module tmr_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  tmr_pkg::reg_req_t     reg_req_i,
  output tmr_pkg::reg_rsp_t     reg_rsp_o,
  output logic                  enable_o,
  output tmr_pkg::tmr_cfg_t     cfg_o,
  input  logic                  force_clr_i,
  input  tmr_pkg::tmr_mode_e    mode_i,
  input  logic [`TMR_CNT_W-1:0] cnt_i [3],
  output logic [2:0]            cnt_clr_o
);

  localparam int unsigned CfgW = $bits(tmr_pkg::tmr_cfg_t);

  logic              ack_q;
  logic              access;
  logic              wr;
  logic              enable_q;
  tmr_pkg::tmr_cfg_t cfg_q;
  logic [31:0]       rdata_d;
  logic [31:0]       rdata_q;

  // A new access starts only once the previous ack is gone
  assign access = reg_req_i.req && !ack_q;
  assign wr     = access && reg_req_i.we;

  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      tmr_pkg::REG_ENABLE: rdata_d[0]                = enable_q;
      tmr_pkg::REG_CONFIG: rdata_d[CfgW-1:0]         = cfg_q;
      tmr_pkg::REG_MODE:   rdata_d[2:0]              = mode_i;
      tmr_pkg::REG_CNT0:   rdata_d[`TMR_CNT_W-1:0]   = cnt_i[0];
      tmr_pkg::REG_CNT1:   rdata_d[`TMR_CNT_W-1:0]   = cnt_i[1];
      tmr_pkg::REG_CNT2:   rdata_d[`TMR_CNT_W-1:0]   = cnt_i[2];
      default:             rdata_d                   = '0;
    endcase
  end

  // Counter clear pulses with the write, the counter clears as ack rises
  assign cnt_clr_o[0] = wr && (reg_req_i.addr == tmr_pkg::REG_CNT0);
  assign cnt_clr_o[1] = wr && (reg_req_i.addr == tmr_pkg::REG_CNT1);
  assign cnt_clr_o[2] = wr && (reg_req_i.addr == tmr_pkg::REG_CNT2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      enable_q <= `TMR_DEFAULT_IN_TMR;
      cfg_q    <= '0;
    end else begin
      if (access) begin
        ack_q <= 1'b1;
      end else if (ack_q && !reg_req_i.req) begin
        ack_q <= 1'b0;
      end

      if (wr && (reg_req_i.addr == tmr_pkg::REG_ENABLE)) begin
        enable_q <= reg_req_i.wdata[0];
      end

      if (wr && (reg_req_i.addr == tmr_pkg::REG_CONFIG)) begin
        cfg_q <= tmr_pkg::tmr_cfg_t'(reg_req_i.wdata[CfgW-1:0]);
      end else if (force_clr_i) begin
        // FSM has taken the forced resynch
        cfg_q.force_resynch <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp_o.ack   = ack_q;
  assign reg_rsp_o.rdata = rdata_q;
  assign enable_o        = enable_q;
  assign cfg_o           = cfg_q;

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_q) |-> $past(reg_req_i.req)
  ) else $error("register ack raised without a request");

endmodule

//--- verilog/tmr_ctrl_fsm.sv
// Redundancy-mode FSM of the TMR group
// Drives setback, resynch and synch requests and the rapid-recovery handshake

`timescale 1ns/10ps

`include "tmr_cfg.svh"

module tmr_ctrl_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  tmr_pkg::tmr_cfg_t   cfg_i,
  input  tmr_pkg::vote_stat_t stat_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  input  logic                sp_store_is_zero_i,
  input  logic                sp_store_will_be_zero_i,
  input  logic                recovery_ack_i,
  output tmr_pkg::tmr_mode_e  mode_o,
  output logic                force_clr_o,
  output logic [2:0]          setback_o,
  output logic                sw_resynch_req_o,
  output logic                sw_synch_req_o,
  output logic                grp_indep_o,
  output logic [2:0]          incr_o,
  output logic                recovery_req_o
);

  localparam tmr_pkg::tmr_mode_e DefaultMode =
    `TMR_DEFAULT_IN_TMR ? tmr_pkg::MODE_RUN : tmr_pkg::MODE_INDEP;

  tmr_pkg::tmr_mode_e mode_d;
  tmr_pkg::tmr_mode_e mode_q;
  logic               ack_seen_d;
  logic               ack_seen_q;
  logic               resynch;

  // Detected mismatch or software trigger both start a recovery
  assign resynch = stat_i.single_mismatch || cfg_i.force_resynch;

  always_comb begin
    mode_d           = mode_q;
    ack_seen_d       = 1'b0;
    setback_o        = 3'b000;
    incr_o           = 3'b000;
    force_clr_o      = 1'b0;
    sw_resynch_req_o = 1'b0;
    sw_synch_req_o   = 1'b0;
    recovery_req_o   = 1'b0;

    case (mode_q)
      tmr_pkg::MODE_RUN: begin
        force_clr_o = cfg_i.force_resynch;
        if (stat_i.single_mismatch) begin
          incr_o = stat_i.error;
        end
        if (resynch) begin
          if (cfg_i.rapid_recovery) begin
            mode_d = tmr_pkg::MODE_RAPID;
          end else if (!cfg_i.delay_resynch) begin
            mode_d = tmr_pkg::MODE_UNLOAD;
          end
        end
      end

      tmr_pkg::MODE_UNLOAD: begin
        sw_resynch_req_o = 1'b1;
        // Software has stored the state once the stack store is nonzero
        if (!sp_store_is_zero_i) begin
          mode_d = tmr_pkg::MODE_RELOAD;
          if (cfg_i.setback) begin
            setback_o = 3'b111;
          end
        end
      end

      tmr_pkg::MODE_RELOAD: begin
        if (sp_store_is_zero_i) begin
          mode_d = tmr_pkg::MODE_RUN;
        end else if ((stat_i.single_mismatch || stat_i.failure) && cfg_i.setback &&
                     cfg_i.reload_setback && !sp_store_will_be_zero_i) begin
          // Error while reloading, restart all three cores
          setback_o = 3'b111;
        end
      end

      tmr_pkg::MODE_RAPID: begin
        // Request until ack, then wait for ack to fall
        recovery_req_o = !ack_seen_q;
        ack_seen_d     = ack_seen_q || recovery_ack_i;
        if (ack_seen_q && !recovery_ack_i) begin
          mode_d     = tmr_pkg::MODE_RUN;
          ack_seen_d = 1'b0;
        end
      end

      default: begin
        // Independent cores wait for software to synchronise them
        if (enable_i) begin
          sw_synch_req_o = 1'b1;
          if (cores_synch_i) begin
            mode_d = tmr_pkg::MODE_RELOAD;
            if (cfg_i.setback) begin
              setback_o = 3'b111;
            end
          end
        end
      end
    endcase

    // Before the cores fetch, the mode simply follows enable
    if (!fetch_en_i) begin
      if (enable_i) begin
        mode_d         = tmr_pkg::MODE_RUN;
        sw_synch_req_o = 1'b0;
      end else begin
        mode_d = tmr_pkg::MODE_INDEP;
      end
    end

    // Leaving lockstep is allowed at any time from run
    if ((mode_q == tmr_pkg::MODE_RUN) && !enable_i) begin
      mode_d = tmr_pkg::MODE_INDEP;
      if (cfg_i.setback) begin
        setback_o = 3'b110;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= DefaultMode;
      ack_seen_q <= 1'b0;
    end else begin
      mode_q     <= mode_d;
      ack_seen_q <= ack_seen_d;
    end
  end

  assign mode_o      = mode_q;
  assign grp_indep_o = (mode_q == tmr_pkg::MODE_INDEP);

  a_req_in_rapid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    recovery_req_o |-> (mode_q == tmr_pkg::MODE_RAPID)
  ) else $error("recovery request outside rapid recovery");

endmodule

//--- verilog/tmr_subsys_top.sv
// TMR subsystem top level
// Voters for data and bus fields, mode FSM, mismatch counters and registers

`timescale 1ns/10ps

`include "tmr_cfg.svh"

module tmr_subsys_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tmr_pkg::reg_req_t      reg_req_i,
  output tmr_pkg::reg_rsp_t      reg_rsp_o,
  input  logic [`TMR_DATA_W-1:0] core0_data_i,
  input  logic [`TMR_DATA_W-1:0] core1_data_i,
  input  logic [`TMR_DATA_W-1:0] core2_data_i,
  input  tmr_pkg::core_bus_t     core0_bus_i,
  input  tmr_pkg::core_bus_t     core1_bus_i,
  input  tmr_pkg::core_bus_t     core2_bus_i,
  output logic [`TMR_DATA_W-1:0] voted_data_o,
  output tmr_pkg::core_bus_t     voted_bus_o,
  input  logic                   fetch_en_i,
  input  logic                   cores_synch_i,
  input  logic                   sp_store_is_zero_i,
  input  logic                   sp_store_will_be_zero_i,
  input  logic                   recovery_ack_i,
  output logic [2:0]             setback_o,
  output logic                   sw_resynch_req_o,
  output logic                   sw_synch_req_o,
  output logic                   grp_indep_o,
  output logic                   recovery_req_o
);

  tmr_pkg::vote_stat_t   stat_data;
  tmr_pkg::vote_stat_t   stat_bus;
  tmr_pkg::vote_stat_t   stat;
  tmr_pkg::tmr_cfg_t     cfg;
  tmr_pkg::tmr_mode_e    mode;
  logic                  enable;
  logic                  force_clr;
  logic [2:0]            incr;
  logic [2:0]            cnt_clr;
  logic [`TMR_CNT_W-1:0] cnt [3];

  tmr_voter #(
    .payload_t(logic [`TMR_DATA_W-1:0])
  ) u_vote_data (
    .core0_i(core0_data_i),
    .core1_i(core1_data_i),
    .core2_i(core2_data_i),
    .voted_o(voted_data_o),
    .stat_o (stat_data)
  );

  tmr_voter #(
    .payload_t(tmr_pkg::core_bus_t)
  ) u_vote_bus (
    .core0_i(core0_bus_i),
    .core1_i(core1_bus_i),
    .core2_i(core2_bus_i),
    .voted_o(voted_bus_o),
    .stat_o (stat_bus)
  );

  // Either word deviating counts as a deviation of that core
  assign stat = tmr_pkg::vote_stat_t'(stat_data | stat_bus);

  tmr_ctrl_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .enable_i               (enable),
    .cfg_i                  (cfg),
    .stat_i                 (stat),
    .fetch_en_i,
    .cores_synch_i,
    .sp_store_is_zero_i,
    .sp_store_will_be_zero_i,
    .recovery_ack_i,
    .mode_o                 (mode),
    .force_clr_o            (force_clr),
    .setback_o,
    .sw_resynch_req_o,
    .sw_synch_req_o,
    .grp_indep_o,
    .incr_o                 (incr),
    .recovery_req_o
  );

  tmr_mismatch_cnt u_cnt (
    .clk_i,
    .rst_ni,
    .incr_i(incr),
    .clr_i (cnt_clr),
    .cnt_o (cnt)
  );

  tmr_ctrl_regs u_regs (
    .clk_i,
    .rst_ni,
    .reg_req_i,
    .reg_rsp_o,
    .enable_o   (enable),
    .cfg_o      (cfg),
    .force_clr_i(force_clr),
    .mode_i     (mode),
    .cnt_i      (cnt),
    .cnt_clr_o  (cnt_clr)
  );

endmodule

//--- bench/tmr_tb.sv
// TMR subsystem testbench
// Drives register port, core copies and recovery handshake, checks modes and counts

`timescale 1ns/10ps

`include "tmr_cfg.svh"

module tmr_tb;

  localparam int TIMEOUT  = 200;
  localparam int DEV_NONE = 3;
  localparam int DEV_ALL  = 4;
  localparam int NUM_ROWS = 10;

  typedef struct {
    string              name;
    logic [4:0]         cfg;
    int                 dev;
    tmr_pkg::tmr_mode_e mode;
    logic [2:0]         setback;
    int                 cnt [3];
  } row_t;

  logic                   clk_i;
  logic                   rst_ni;
  tmr_pkg::reg_req_t      reg_req;
  tmr_pkg::reg_rsp_t      reg_rsp;
  logic [`TMR_DATA_W-1:0] data [3];
  tmr_pkg::core_bus_t     bus [3];
  logic [`TMR_DATA_W-1:0] voted_data;
  tmr_pkg::core_bus_t     voted_bus;
  logic                   fetch_en;
  logic                   cores_synch;
  logic                   sp_is_zero;
  logic                   sp_will_be_zero;
  logic                   recovery_ack;
  logic [2:0]             setback;
  logic                   sw_resynch_req;
  logic                   sw_synch_req;
  logic                   grp_indep;
  logic                   recovery_req;

  row_t rows [NUM_ROWS];
  int   ack_lat;
  int   rel_lat;

  tmr_subsys_top dut0 (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .reg_req_i              (reg_req),
    .reg_rsp_o              (reg_rsp),
    .core0_data_i           (data[0]),
    .core1_data_i           (data[1]),
    .core2_data_i           (data[2]),
    .core0_bus_i            (bus[0]),
    .core1_bus_i            (bus[1]),
    .core2_bus_i            (bus[2]),
    .voted_data_o           (voted_data),
    .voted_bus_o            (voted_bus),
    .fetch_en_i             (fetch_en),
    .cores_synch_i          (cores_synch),
    .sp_store_is_zero_i     (sp_is_zero),
    .sp_store_will_be_zero_i(sp_will_be_zero),
    .recovery_ack_i         (recovery_ack),
    .setback_o              (setback),
    .sw_resynch_req_o       (sw_resynch_req),
    .sw_synch_req_o         (sw_synch_req),
    .grp_indep_o            (grp_indep),
    .recovery_req_o         (recovery_req)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [35:0] exp, input logic [35:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "check %s failed", name);
    end
  endtask

  // Raise a request and wait until the block acknowledges it
  task automatic reg_start(input logic [`TMR_ADDR_W-1:0] addr, input logic we,
                           input logic [31:0] wdata);
    @(posedge clk_i);
    reg_req.req   <= 1'b1;
    reg_req.we    <= we;
    reg_req.addr  <= addr;
    reg_req.wdata <= wdata;
    ack_lat = 0;
    do begin
      @(posedge clk_i);
      ack_lat++;
      @(negedge clk_i);
    end while (!reg_rsp.ack && ack_lat < TIMEOUT);
    if (!reg_rsp.ack) fail_run("register ack never rose");
  endtask

  task automatic reg_finish();
    @(posedge clk_i);
    reg_req.req <= 1'b0;
    rel_lat = 0;
    do begin
      @(posedge clk_i);
      rel_lat++;
      @(negedge clk_i);
    end while (reg_rsp.ack && rel_lat < TIMEOUT);
    if (reg_rsp.ack) fail_run("register ack stayed high after the request was dropped");
  endtask

  task automatic reg_write(input logic [`TMR_ADDR_W-1:0] addr, input logic [31:0] wdata);
    reg_start(addr, 1'b1, wdata);
    reg_finish();
  endtask

  task automatic check_reg(input string name, input logic [`TMR_ADDR_W-1:0] addr,
                           input logic [31:0] exp);
    logic [31:0] rdata;
    reg_start(addr, 1'b0, 32'h0);
    rdata = reg_rsp.rdata;
    reg_finish();
    check_val(name, exp, rdata);
  endtask

  task automatic wait_recovery_req(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (recovery_req !== level && n < TIMEOUT);
    if (recovery_req !== level) fail_run("recovery request did not reach the expected level");
  endtask

  task automatic wait_sw_synch();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (sw_synch_req !== 1'b1 && n < TIMEOUT);
    if (sw_synch_req !== 1'b1) fail_run("software synch request never rose");
  endtask

  // One cycle with random data, the chosen core deviating
  task automatic apply_vote(input int dev, input string name);
    logic [`TMR_DATA_W-1:0] base;
    logic [`TMR_DATA_W-1:0] dmask;
    logic [35:0]            bbase;
    logic [35:0]            bmask;
    base          = $urandom();
    dmask         = $urandom() | 32'h1;
    bbase[31:0]   = $urandom();
    bbase[35:32]  = 4'($urandom());
    bmask         = {4'h0, $urandom() | 32'h1};
    @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      data[i] <= base;
      bus[i]  <= bbase;
    end
    if (dev < 3) begin
      data[dev] <= base ^ dmask;
      bus[dev]  <= bbase ^ bmask;
    end else if (dev == DEV_ALL) begin
      // Odd mask and its shift differ, so no two copies agree
      data[1] <= base ^ dmask;
      data[2] <= base ^ (dmask << 1);
      bus[1]  <= bbase ^ bmask;
      bus[2]  <= bbase ^ (bmask << 1);
    end
    @(negedge clk_i);
    // Majority keeps base, and core0 keeps base when all differ
    check_val({name, " voted data"}, base, voted_data);
    check_val({name, " voted bus"}, bbase, voted_bus);
    @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      data[i] <= base;
      bus[i]  <= bbase;
    end
  endtask

  task automatic run_rapid(input string name);
    wait_recovery_req(1'b1);
    @(posedge clk_i);
    recovery_ack <= 1'b1;
    wait_recovery_req(1'b0);
    @(posedge clk_i);
    recovery_ack <= 1'b0;
    check_reg({name, " mode after recovery"}, tmr_pkg::REG_MODE, tmr_pkg::MODE_RUN);
  endtask

  task automatic run_unload(input string name, input logic [2:0] exp_setback);
    check_val({name, " resynch req"}, 1'b1, sw_resynch_req);
    @(posedge clk_i);
    sp_is_zero <= 1'b0;
    @(negedge clk_i);
    check_val({name, " setback"}, exp_setback, setback);
    check_reg({name, " mode reload"}, tmr_pkg::REG_MODE, tmr_pkg::MODE_RELOAD);
    @(posedge clk_i);
    sp_is_zero <= 1'b1;
    check_reg({name, " mode after reload"}, tmr_pkg::REG_MODE, tmr_pkg::MODE_RUN);
  endtask

  task automatic fill_table();
    rows[0] = '{"dev0_count", 5'h04, 0, tmr_pkg::MODE_RUN, 3'b000, '{1, 0, 0}};
    rows[1] = '{"dev1_count", 5'h04, 1, tmr_pkg::MODE_RUN, 3'b000, '{1, 1, 0}};
    rows[2] = '{"dev2_count", 5'h04, 2, tmr_pkg::MODE_RUN, 3'b000, '{1, 1, 1}};
    rows[3] = '{"no_deviation", 5'h04, DEV_NONE, tmr_pkg::MODE_RUN, 3'b000, '{1, 1, 1}};
    rows[4] = '{"rapid_dev1", 5'h08, 1, tmr_pkg::MODE_RAPID, 3'b000, '{1, 2, 1}};
    rows[5] = '{"unload_setback", 5'h01, 2, tmr_pkg::MODE_UNLOAD, 3'b111, '{1, 2, 2}};
    rows[6] = '{"unload_plain", 5'h00, 0, tmr_pkg::MODE_UNLOAD, 3'b000, '{2, 2, 2}};
    rows[7] = '{"force_unload", 5'h11, DEV_NONE, tmr_pkg::MODE_UNLOAD, 3'b111, '{2, 2, 2}};
    rows[8] = '{"force_rapid", 5'h18, DEV_NONE, tmr_pkg::MODE_RAPID, 3'b000, '{2, 2, 2}};
    rows[9] = '{"all_differ", 5'h04, DEV_ALL, tmr_pkg::MODE_RUN, 3'b000, '{2, 2, 2}};
  endtask

  initial begin
    void'($urandom(43));
    rst_ni          = 1'b0;
    reg_req         = '0;
    data            = '{default: '0};
    bus             = '{default: '0};
    fetch_en        = 1'b0;
    cores_synch     = 1'b0;
    sp_is_zero      = 1'b1;
    sp_will_be_zero = 1'b1;
    recovery_ack    = 1'b0;
    fill_table();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset state and a plain configuration round trip
    @(negedge clk_i);
    check_val("reset grp_indep", 1'b1, grp_indep);
    check_val("reset recovery req", 1'b0, recovery_req);
    check_val("reset setback", 3'b000, setback);
    check_reg("reset mode", tmr_pkg::REG_MODE, tmr_pkg::MODE_INDEP);
    reg_write(tmr_pkg::REG_CONFIG, 32'h0B);
    check_val("ack latency", 1, ack_lat);
    check_val("ack release", 1, rel_lat);
    check_reg("config readback", tmr_pkg::REG_CONFIG, 32'h0B);
    check_reg("unknown address", 4'hF, 32'h0);

    // Mode follows enable before fetch starts
    reg_write(tmr_pkg::REG_ENABLE, 32'h1);
    check_reg("prefetch enable mode", tmr_pkg::REG_MODE, tmr_pkg::MODE_RUN);
    reg_write(tmr_pkg::REG_ENABLE, 32'h0);
    check_reg("prefetch disable mode", tmr_pkg::REG_MODE, tmr_pkg::MODE_INDEP);

    // Software synch from independent mode
    reg_write(tmr_pkg::REG_CONFIG, 32'h01);
    @(posedge clk_i);
    fetch_en <= 1'b1;
    reg_write(tmr_pkg::REG_ENABLE, 32'h1);
    wait_sw_synch();
    @(posedge clk_i);
    cores_synch <= 1'b1;
    sp_is_zero  <= 1'b0;
    @(negedge clk_i);
    check_val("synch setback", 3'b111, setback);
    @(posedge clk_i);
    cores_synch <= 1'b0;
    check_reg("synch mode reload", tmr_pkg::REG_MODE, tmr_pkg::MODE_RELOAD);
    @(posedge clk_i);
    sp_is_zero <= 1'b1;
    check_reg("synch mode run", tmr_pkg::REG_MODE, tmr_pkg::MODE_RUN);

    for (int r = 0; r < NUM_ROWS; r++) begin
      reg_write(tmr_pkg::REG_CONFIG, {27'd0, rows[r].cfg});
      apply_vote(rows[r].dev, rows[r].name);
      check_reg({rows[r].name, " mode"}, tmr_pkg::REG_MODE, rows[r].mode);
      if (rows[r].mode == tmr_pkg::MODE_RAPID) begin
        run_rapid(rows[r].name);
      end else if (rows[r].mode == tmr_pkg::MODE_UNLOAD) begin
        run_unload(rows[r].name, rows[r].setback);
      end else begin
        check_val({rows[r].name, " setback"}, rows[r].setback, setback);
      end
      // Forced resynch bit clears itself once taken
      if (rows[r].cfg[4]) begin
        check_reg({rows[r].name, " force cleared"}, tmr_pkg::REG_CONFIG,
                  {27'd0, rows[r].cfg & 5'h0F});
      end
      for (int c = 0; c < 3; c++) begin
        check_reg($sformatf("%s cnt%0d", rows[r].name, c),
                  tmr_pkg::REG_CNT0 + `TMR_ADDR_W'(c), rows[r].cnt[c]);
      end
    end

    reg_write(tmr_pkg::REG_CNT1, 32'h0);
    check_reg("cnt1 cleared", tmr_pkg::REG_CNT1, 32'h0);
    check_reg("cnt0 kept", tmr_pkg::REG_CNT0, 32'h2);

    // Leaving lockstep with setback configured
    reg_write(tmr_pkg::REG_CONFIG, 32'h01);
    reg_start(tmr_pkg::REG_ENABLE, 1'b1, 32'h0);
    check_val("disable setback", 3'b110, setback);
    reg_finish();
    check_val("disable grp_indep", 1'b1, grp_indep);
    check_reg("disable mode", tmr_pkg::REG_MODE, tmr_pkg::MODE_INDEP);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/tmr_pkg.sv
verilog/tmr_voter.sv
verilog/tmr_mismatch_cnt.sv
verilog/tmr_ctrl_regs.sv
verilog/tmr_ctrl_fsm.sv
verilog/tmr_subsys_top.sv
bench/tmr_tb.sv
